// File: source/noc_pkg.sv
package noc_pkg;

  localparam int n_ports    = 5;
  localparam int flit_w     = 32;
  localparam int fifo_depth = 4;
  localparam int fifo_aw    = $clog2(fifo_depth);
  localparam int cnt_w      = 16;
  localparam int cfg_aw     = 2;

  localparam logic [n_ports:0] st_idle = {{n_ports{1'b0}}, 1'b1};

  localparam logic [cfg_aw-1:0] addr_mask  = 2'd0;
  localparam logic [cfg_aw-1:0] addr_pkts  = 2'd1;
  localparam logic [cfg_aw-1:0] addr_flits = 2'd2;

  localparam logic [n_ports-1:0] mask_reset = '1;

  typedef enum logic [1:0] {
    kind_header = 2'd0,
    kind_body   = 2'd1,
    kind_tail   = 2'd2
  } flit_kind_t;

  typedef struct packed {
    flit_kind_t         kind;
    logic [3:0]         dst_x;
    logic [3:0]         dst_y;
    logic [7:0]         src;
    logic [flit_w-19:0] len;
  } hdr_view_t;

  typedef struct packed {
    flit_kind_t        kind;
    logic [flit_w-3:0] payload;
  } body_view_t;

  typedef union packed {
    hdr_view_t  hdr;
    body_view_t body;
  } flit_u;

  typedef struct packed {
    logic  valid;
    flit_u flit;
  } in_flit_t;

  typedef struct packed {
    flit_u flit;
    logic  rts;
  } link_t;

  typedef struct packed {
    logic              we;
    logic [cfg_aw-1:0] addr;
    logic [cnt_w-1:0]  wdata;
  } cfg_req_t;

endpackage

// File: source/flit_fifo.sv
`timescale 1ns/100ps

module flit_fifo
  import noc_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  in_flit_t wr,
  input  logic     pop,
  output logic     req,
  output flit_u    head,
  output logic     credit
);

  flit_u mem [fifo_depth];

  logic [fifo_aw-1:0] rd_ptr;
  logic [fifo_aw-1:0] wr_ptr;
  logic [fifo_aw:0]   count;

  logic full;
  logic push;
  logic do_pop;

  function automatic logic [fifo_aw-1:0] next_ptr(input logic [fifo_aw-1:0] ptr);
    logic [fifo_aw-1:0] nxt;
    if (ptr == fifo_aw'(fifo_depth - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign full   = (count == (fifo_aw + 1)'(fifo_depth));
  assign req    = (count != '0);
  assign push   = wr.valid && !full; // Sender holds a credit.
  assign do_pop = pop && req;
  assign head   = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr.flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      credit <= do_pop; // One credit back per popped flit.
    end
  end

endmodule

// File: source/out_arbiter.sv
`timescale 1ns/100ps

module out_arbiter
  import noc_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic [n_ports-1:0] req,
  input  logic [n_ports-1:0] en_mask,
  input  logic               dcts,
  output logic [n_ports-1:0] grant,
  output logic [n_ports-1:0] xbar_sel,
  output logic               rts
);

  // Bit 0 is idle, bit p+1 serves port p.
  logic [n_ports:0] state;
  logic [n_ports:0] next_state;

  logic [n_ports-1:0] eff_req;
  logic               rts_next;
  logic               stall;
  logic               xfer;
  int                 cur_port;

  // Index of the port being served, zero when idle.
  function automatic int sel_to_port(input logic [n_ports-1:0] sel);
    int port;
    port = 0;
    for (int i = 0; i < n_ports; i++) begin
      if (sel[i]) begin
        port = i;
      end
    end
    return port;
  endfunction

  // First requester at or after start, wrapping through L, N, E, W, S.
  function automatic logic [n_ports:0] rotate_pick(input logic [n_ports-1:0] r,
                                                   input int start);
    logic [n_ports:0] pick;
    int               idx;
    pick = st_idle;
    for (int i = n_ports - 1; i >= 0; i--) begin
      idx = start + i;
      if (idx >= n_ports) begin
        idx = idx - n_ports;
      end
      if (r[idx]) begin
        pick          = '0;
        pick[idx + 1] = 1'b1;
      end
    end
    return pick;
  endfunction

  assign eff_req  = req & en_mask;
  assign xbar_sel = state[n_ports:1];
  assign cur_port = sel_to_port(xbar_sel);
  assign stall    = rts && !dcts;
  assign xfer     = rts && dcts;
  assign grant    = xbar_sel & {n_ports{xfer}};

  always_comb begin
    next_state = rotate_pick(eff_req, cur_port);
  end

  always_comb begin
    if (stall) begin
      rts_next = 1'b1; // Keep offering until dcts.
    end else if (xfer) begin
      rts_next = 1'b0;
    end else begin
      // Raise only once the selection has settled.
      rts_next = (state != st_idle) && (next_state == state);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
      rts   <= 1'b0;
    end else begin
      if (!stall) begin
        state <= next_state;
      end
      rts <= rts_next;
    end
  end

endmodule

// File: source/port_cfg.sv
`timescale 1ns/100ps

module port_cfg
  import noc_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  cfg_req_t           cfg,
  output logic [cnt_w-1:0]   rdata,
  output logic [n_ports-1:0] en_mask,
  input  logic               xfer,
  input  flit_u              xfer_flit
);

  logic [cnt_w-1:0] pkt_cnt;
  logic [cnt_w-1:0] flit_cnt;
  logic             is_head;
  logic             clr_pkts;
  logic             clr_flits;

  assign is_head   = (xfer_flit.hdr.kind == kind_header);
  assign clr_pkts  = cfg.we && (cfg.addr == addr_pkts);
  assign clr_flits = cfg.we && (cfg.addr == addr_flits);

  always_ff @(posedge clk) begin
    if (rst) begin
      en_mask  <= mask_reset;
      pkt_cnt  <= '0;
      flit_cnt <= '0;
    end else begin
      if (cfg.we && (cfg.addr == addr_mask)) begin
        en_mask <= cfg.wdata[n_ports-1:0];
      end
      if (clr_pkts) begin
        pkt_cnt <= '0;
      end else if (xfer && is_head && (pkt_cnt != '1)) begin
        pkt_cnt <= pkt_cnt + 1'b1; // Saturates.
      end
      if (clr_flits) begin
        flit_cnt <= '0;
      end else if (xfer && (flit_cnt != '1)) begin
        flit_cnt <= flit_cnt + 1'b1;
      end
    end
  end

  always_comb begin
    case (cfg.addr)
      addr_mask:  rdata = {{(cnt_w - n_ports){1'b0}}, en_mask};
      addr_pkts:  rdata = pkt_cnt;
      addr_flits: rdata = flit_cnt;
      default:    rdata = '0;
    endcase
  end

endmodule

// File: source/out_link.sv
`timescale 1ns/100ps

module out_link
  import noc_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  flit_u              heads [n_ports],
  input  logic [n_ports-1:0] xbar_sel,
  input  logic               rts,
  input  logic               dcts,
  output link_t              link,
  output logic               xfer,
  output flit_u              xfer_flit
);

  flit_u sel_flit;
  flit_u hold;

  // One-hot select, nothing when idle.
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < n_ports; i++) begin
      if (xbar_sel[i]) begin
        sel_flit = heads[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hold <= '0;
    end else if (!rts) begin
      hold <= sel_flit; // Frozen while offered.
    end
  end

  assign link.flit = hold;
  assign link.rts  = rts;
  assign xfer      = rts && dcts;
  assign xfer_flit = hold;

endmodule

// File: source/out_port_top.sv
`timescale 1ns/100ps

module out_port_top
  import noc_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  in_flit_t           in_flits [n_ports],
  output logic [n_ports-1:0] credits,
  input  logic               dcts,
  output link_t              link,
  input  cfg_req_t           cfg,
  output logic [cnt_w-1:0]   cfg_rdata
);

  logic [n_ports-1:0] req;
  logic [n_ports-1:0] grant;
  logic [n_ports-1:0] xbar_sel;
  logic [n_ports-1:0] en_mask;
  logic               rts;
  logic               xfer;
  flit_u              xfer_flit;
  flit_u              heads [n_ports];

  // Input buffers in L, N, E, W, S order.
  for (genvar p = 0; p < n_ports; p++) begin : g_in
    flit_fifo fifo_i (
      .clk    (clk),
      .rst    (rst),
      .wr     (in_flits[p]),
      .pop    (grant[p]),
      .req    (req[p]),
      .head   (heads[p]),
      .credit (credits[p])
    );
  end

  out_arbiter arb_i (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .en_mask  (en_mask),
    .dcts     (dcts),
    .grant    (grant),
    .xbar_sel (xbar_sel),
    .rts      (rts)
  );

  port_cfg cfg_i (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .rdata     (cfg_rdata),
    .en_mask   (en_mask),
    .xfer      (xfer),
    .xfer_flit (xfer_flit)
  );

  out_link link_i (
    .clk       (clk),
    .rst       (rst),
    .heads     (heads),
    .xbar_sel  (xbar_sel),
    .rts       (rts),
    .dcts      (dcts),
    .link      (link),
    .xfer      (xfer),
    .xfer_flit (xfer_flit)
  );

endmodule

// File: dv/out_port_asserts.sv
`timescale 1ns/100ps

module out_port_asserts
  import noc_pkg::*;
(
  input logic               clk,
  input logic               rst,
  input logic [n_ports-1:0] grant,
  input logic               rts,
  input logic               dcts,
  input logic [n_ports:0]   state
);

  int fail_count = 0;

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else begin
      $error("grant has more than one bit set");
      fail_count++;
    end

  a_grant_xfer: assert property (@(posedge clk) disable iff (rst)
    (grant != '0) == (rts && dcts))
    else begin
      $error("grant does not match the rts and dcts transfer cycle");
      fail_count++;
    end

  // Back-pressure keeps the offer in place.
  a_stall_hold: assert property (@(posedge clk) disable iff (rst)
    (rts && !dcts) |=> ($stable(state) && rts))
    else begin
      $error("arbiter state or rts moved while dcts was low");
      fail_count++;
    end

endmodule

bind out_arbiter out_port_asserts asserts_i (
  .clk   (clk),
  .rst   (rst),
  .grant (grant),
  .rts   (rts),
  .dcts  (dcts),
  .state (state)
);

// File: dv/out_port_tb.sv
`timescale 1ns/100ps

module out_port_tb
  import noc_pkg::*;
();

  localparam int max_cycles = 4000; // Tests need roughly 500.
  localparam int port_l = 0;
  localparam int port_n = 1;
  localparam int port_e = 2;
  localparam int port_w = 3;
  localparam int port_s = 4;

  logic               clk = 1'b0;
  logic               rst;
  in_flit_t           in_flits [n_ports];
  logic [n_ports-1:0] credits;
  logic               dcts;
  link_t              link;
  cfg_req_t           cfg;
  logic [cnt_w-1:0]   cfg_rdata;

  flit_u              send_q [n_ports][$];
  flit_u              exp_q [n_ports][$];
  int                 arrival_q [$];
  int                 cred [n_ports];
  int                 credit_seen [n_ports];
  logic [n_ports-1:0] blocked = '0;
  logic               random_dcts = 1'b0;
  int                 stretch = 0;
  int                 seed = 32'h631a2819;
  int                 cycles = 0;
  int                 errors = 0;
  int                 checks = 0;
  int                 total;
  int                 sent_hdrs = 0;
  int                 sent_flits = 0;
  int                 xfers = 0;
  logic               prev_stall;
  logic               prev_xfer;
  flit_u              prev_flit;

  always #10 clk = ~clk;

  out_port_top dut_i (
    .clk       (clk),
    .rst       (rst),
    .in_flits  (in_flits),
    .credits   (credits),
    .dcts      (dcts),
    .link      (link),
    .cfg       (cfg),
    .cfg_rdata (cfg_rdata)
  );

  task automatic compare_flit(input string name, input flit_u got, input flit_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic compare_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic compare_word(input string name, input logic [cnt_w-1:0] got,
                              input logic [cnt_w-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Senders spend a credit per flit and regain one per pulse.
  always @(posedge clk) begin : send_flits
    in_flit_t w;
    for (int p = 0; p < n_ports; p++) begin
      w = '0;
      if (rst) begin
        cred[p] = fifo_depth;
        credit_seen[p] = 0;
      end else begin
        if (credits[p]) begin
          cred[p] = cred[p] + 1;
          credit_seen[p] = credit_seen[p] + 1;
        end
        if (send_q[p].size() > 0 && cred[p] > 0) begin
          w.valid = 1'b1;
          w.flit = send_q[p].pop_front();
          cred[p] = cred[p] - 1;
        end
      end
      in_flits[p] <= w;
    end
  end

  always @(posedge clk) begin
    if (!random_dcts) begin
      dcts <= 1'b1;
    end else if (stretch > 0) begin
      stretch = stretch - 1;
    end else begin
      dcts <= (($random(seed) & 1) != 0);
      stretch = 1 + ($random(seed) & 7);
    end
  end

  task automatic take_flit(input flit_u f);
    int port;
    port = -1;
    for (int p = 0; p < n_ports; p++) begin
      if (port < 0 && exp_q[p].size() > 0 && exp_q[p][0] == f) begin
        port = p;
      end
    end
    checks++;
    if (port < 0) begin
      errors++;
      $display("Flit %h arrived at %0t but no port was waiting for it", f, $time);
    end else begin
      if (blocked[port]) begin
        errors++;
        $display("Flit %h from masked port %0d reached the link at %0t", f, port, $time);
      end
      exp_q[port].delete(0);
      arrival_q.push_back(port);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      prev_stall <= 1'b0;
      prev_xfer  <= 1'b0;
    end else begin
      if (prev_stall) begin
        compare_bit("link.rts under stall", link.rts, 1'b1);
        compare_flit("link.flit under stall", link.flit, prev_flit);
      end
      if (prev_xfer) begin
        compare_bit("link.rts after transfer", link.rts, 1'b0);
      end
      if (link.rts && dcts) begin
        xfers++;
        take_flit(link.flit);
      end
      prev_stall <= link.rts && !dcts;
      prev_xfer  <= link.rts && dcts;
      prev_flit  <= link.flit;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("Timeout after %0d cycles, flits or credits never came back", cycles);
      $display("Verification failed");
      $finish;
    end
  end

  task automatic queue_packet(input int port, input int nflits);
    flit_u f;
    for (int i = 0; i < nflits; i++) begin
      f = '0;
      if (i == 0) begin
        f.hdr.kind  = kind_header;
        f.hdr.dst_x = 4'($random(seed));
        f.hdr.dst_y = 4'($random(seed));
        f.hdr.src   = 8'(port);
        f.hdr.len   = 14'(nflits);
        sent_hdrs++;
      end else begin
        f.body.kind    = (i == nflits - 1) ? kind_tail : kind_body;
        f.body.payload = 30'($random(seed));
      end
      send_q[port].push_back(f);
      exp_q[port].push_back(f);
      sent_flits++;
    end
  endtask

  task automatic wait_drained();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(negedge clk);
      busy = 1'b0;
      for (int p = 0; p < n_ports; p++) begin
        if (send_q[p].size() > 0 || exp_q[p].size() > 0 || cred[p] < fifo_depth) begin
          busy = 1'b1;
        end
      end
    end
  endtask

  task automatic write_cfg(input logic [cfg_aw-1:0] addr, input logic [cnt_w-1:0] data);
    cfg_req_t req;
    req.we    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    @(posedge clk);
    cfg <= req;
    @(posedge clk);
    req.we = 1'b0;
    cfg <= req;
    @(negedge clk);
  endtask

  task automatic read_cfg(input logic [cfg_aw-1:0] addr, output logic [cnt_w-1:0] data);
    cfg_req_t req;
    req.we    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    @(posedge clk);
    cfg <= req;
    @(negedge clk);
    data = cfg_rdata;
  endtask

  task automatic finish_test(input string name, input int first);
    if (errors == first) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: FAILED with %0d errors", name, errors - first);
    end
  endtask

  task automatic test_reset();
    int               first;
    logic [cnt_w-1:0] data;
    first = errors;
    @(negedge clk);
    compare_bit("link.rts", link.rts, 1'b0);
    for (int p = 0; p < n_ports; p++) begin
      compare_bit($sformatf("credits[%0d]", p), credits[p], 1'b0);
    end
    read_cfg(addr_mask, data);
    compare_word("en_mask", data, {{(cnt_w - n_ports){1'b0}}, {n_ports{1'b1}}});
    finish_test("reset", first);
  endtask

  task automatic test_packet_e();
    int first;
    int pulses;
    first = errors;
    wait_drained();
    pulses = credit_seen[port_e];
    queue_packet(port_e, 4);
    wait_drained();
    compare_word("credit pulses on E", cnt_w'(credit_seen[port_e] - pulses), 16'd4);
    finish_test("packet_on_e", first);
  endtask

  task automatic test_order();
    int first;
    int xfers_before;
    first = errors;
    wait_drained();
    arrival_q.delete();
    xfers_before = xfers;
    for (int p = 0; p < n_ports; p++) begin
      queue_packet(p, 1);
    end
    wait_drained();
    compare_word("transfer count", cnt_w'(xfers - xfers_before), cnt_w'(n_ports));
    // L, N, E, W, S from idle.
    foreach (arrival_q[i]) begin
      compare_word($sformatf("arrival %0d port", i), cnt_w'(arrival_q[i]), cnt_w'(i));
    end
    finish_test("arbitration_order", first);
  endtask

  task automatic test_backpressure();
    int first;
    int port;
    int flits_before;
    int xfers_before;
    first = errors;
    wait_drained();
    flits_before = sent_flits;
    xfers_before = xfers;
    random_dcts = 1'b1;
    for (int i = 0; i < 12; i++) begin
      port = ($random(seed) & 32'h7fff_ffff) % n_ports;
      queue_packet(port, 1 + (($random(seed) & 32'h7fff_ffff) % 4));
    end
    wait_drained();
    random_dcts = 1'b0;
    compare_word("flits through stalls", cnt_w'(xfers - xfers_before),
                 cnt_w'(sent_flits - flits_before));
    finish_test("back_pressure", first);
  endtask

  task automatic test_mask();
    int               first;
    logic [cnt_w-1:0] data;
    first = errors;
    wait_drained();
    write_cfg(addr_mask, 16'h001d); // N off.
    read_cfg(addr_mask, data);
    compare_word("en_mask", data, 16'h001d);
    blocked[port_n] = 1'b1;
    queue_packet(port_n, 3);
    queue_packet(port_e, 2);
    while (exp_q[port_e].size() > 0) begin
      @(negedge clk);
    end
    repeat (20) @(negedge clk);
    compare_word("flits held on N", cnt_w'(exp_q[port_n].size()), 16'd3);
    blocked[port_n] = 1'b0;
    write_cfg(addr_mask, 16'h001f);
    wait_drained();
    finish_test("port_mask", first);
  endtask

  task automatic test_counters();
    int               first;
    logic [cnt_w-1:0] data;
    first = errors;
    wait_drained();
    write_cfg(addr_pkts, 16'h0000);
    write_cfg(addr_flits, 16'h0000);
    sent_hdrs = 0;
    sent_flits = 0;
    queue_packet(port_l, 3);
    queue_packet(port_w, 1);
    queue_packet(port_s, 4);
    queue_packet(port_n, 2);
    queue_packet(port_l, 2);
    wait_drained();
    read_cfg(addr_pkts, data);
    compare_word("packet count", data, cnt_w'(sent_hdrs));
    read_cfg(addr_flits, data);
    compare_word("flit count", data, cnt_w'(sent_flits));
    write_cfg(addr_pkts, 16'h1234); // Any value clears.
    read_cfg(addr_pkts, data);
    compare_word("packet count after clear", data, 16'd0);
    read_cfg(addr_flits, data);
    compare_word("flit count kept", data, cnt_w'(sent_flits));
    write_cfg(addr_flits, 16'hbeef);
    read_cfg(addr_flits, data);
    compare_word("flit count after clear", data, 16'd0);
    finish_test("counters", first);
  endtask

  initial begin
    rst  <= 1'b1;
    dcts <= 1'b1;
    cfg  <= '0;
    for (int p = 0; p < n_ports; p++) begin
      in_flits[p] <= '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    test_reset();
    test_packet_e();
    test_order();
    test_backpressure();
    test_mask();
    test_counters();
    total = errors + dut_i.arb_i.asserts_i.fail_count;
    $display("Summary: %0d checks, %0d check errors, %0d assertion failures",
             checks, errors, dut_i.arb_i.asserts_i.fail_count);
    if (total == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: sources.f
source/noc_pkg.sv
source/flit_fifo.sv
source/out_arbiter.sv
source/port_cfg.sv
source/out_link.sv
source/out_port_top.sv
dv/out_port_asserts.sv
dv/out_port_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= out_port_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_TEXT ?= Verification passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
